/* Bender.yml */
package:
  name: mini_game

sources:
  - logic/game_pkg.sv
  - logic/rom_slot_if.sv
  - logic/vid_timer.sv
  - logic/char_fetch.sv
  - logic/rom_arbiter.sv
  - logic/pal_lut.sv
  - logic/mini_game.sv
  - target: test
    files:
      - bench/mini_game_properties.sv
      - bench/mini_game_tb.sv

/* bench/mini_game_properties.sv */
`default_nettype none

module mini_game_properties (
    input logic        clk,
    input logic        arst_n,
    input logic        ba_rd,
    input logic [21:0] ba_addr,
    input logic        ba_ack,
    input logic        ba_dok,
    input logic        map_cs,
    input logic        map_ok,
    input logic        tile_cs,
    input logic        tile_ok
);
    logic read_open;
    logic failed = 1'b0;

    // Open from the accepted request until its data word
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            read_open <= 1'b0;
        end else if (ba_rd && ba_ack) begin
            read_open <= 1'b1;
        end else if (ba_dok) begin
            read_open <= 1'b0;
        end
    end

    request_held: assert property (@(posedge clk) disable iff (!arst_n)
        ba_rd && !ba_ack |=> ba_rd && $stable(ba_addr))
        else begin
            failed = 1'b1;
            $error("ba_rd or ba_addr changed before ba_ack");
        end

    one_outstanding: assert property (@(posedge clk) disable iff (!arst_n)
        read_open |-> !ba_rd)
        else begin
            failed = 1'b1;
            $error("new ba_rd raised before ba_dok of the previous read");
        end

    map_ok_with_cs: assert property (@(posedge clk) disable iff (!arst_n)
        map_ok |-> map_cs)
        else begin
            failed = 1'b1;
            $error("map slot ok without map slot cs");
        end

    tile_ok_with_cs: assert property (@(posedge clk) disable iff (!arst_n)
        tile_ok |-> tile_cs)
        else begin
            failed = 1'b1;
            $error("tile slot ok without tile slot cs");
        end

endmodule

bind rom_arbiter mini_game_properties u_props (
    .clk     ( clk          ),
    .arst_n  ( arst_n       ),
    .ba_rd   ( ba_rd        ),
    .ba_addr ( ba_addr      ),
    .ba_ack  ( ba_ack       ),
    .ba_dok  ( ba_dok       ),
    .map_cs  ( map_slot.cs  ),
    .map_ok  ( map_slot.ok  ),
    .tile_cs ( tile_slot.cs ),
    .tile_ok ( tile_slot.ok )
);

`default_nettype wire

/* bench/mini_game_tb.sv */
`default_nettype none

module mini_game_tb;
    import game_pkg::*;

    localparam int frame_cycles = h_total * v_total * 2;
    // Raster test takes about two frames and each of the four image tests at most two
    localparam int timeout_cycles = 13 * frame_cycles;
    localparam int tile_words = 2 << tile_aw;

    localparam int scan_count = 0;
    localparam int scan_image = 1;
    localparam int scan_flat  = 2;

    typedef enum logic [1:0] {
        bank_idle,
        bank_ack,
        bank_data,
        bank_dok
    } bank_state_t;

    logic        clk       = 1'b0;
    logic        arst_n    = 1'b0;
    logic        char_en   = 1'b1;
    logic        pal_we    = 1'b0;
    logic [3:0]  pal_addr  = 4'd0;
    logic [14:0] pal_din   = 15'd0;
    logic        ba_ack    = 1'b0;
    logic        ba_dok    = 1'b0;
    logic        ba_rdy    = 1'b0;
    logic [15:0] data_read = 16'd0;

    logic        pxl2_cen;
    logic        pxl_cen;
    logic [4:0]  red;
    logic [4:0]  green;
    logic [4:0]  blue;
    logic        HS;
    logic        VS;
    logic        LHBL_dly;
    logic        LVBL_dly;
    logic        ba_rd;
    logic [21:0] ba_addr;

    logic [15:0] tile_mem [tile_words];
    logic [14:0] pal_ref [pal_entries];
    logic [15:0] lfsr_q = 16'd83;
    int          cycle_cnt = 0;
    logic        bp_en = 1'b0;
    bank_state_t bank_st = bank_idle;
    logic [21:0] rd_addr;
    int          wait_cnt;
    int          extra_cycles;
    int          delay_credit = 0;

    mini_game uut (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .char_en   ( char_en   ),
        .pal_we    ( pal_we    ),
        .pal_addr  ( pal_addr  ),
        .pal_din   ( pal_din   ),
        .ba_ack    ( ba_ack    ),
        .ba_dok    ( ba_dok    ),
        .ba_rdy    ( ba_rdy    ),
        .data_read ( data_read ),
        .pxl2_cen  ( pxl2_cen  ),
        .pxl_cen   ( pxl_cen   ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      ),
        .HS        ( HS        ),
        .VS        ( VS        ),
        .LHBL_dly  ( LHBL_dly  ),
        .LVBL_dly  ( LVBL_dly  ),
        .ba_rd     ( ba_rd     ),
        .ba_addr   ( ba_addr   )
    );

    always #5 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
            $display("Checks failed");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
            $display("Checks failed");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    always @(posedge clk) begin
        if (uut.u_arbiter.u_props.failed) begin
            $display("A bound assertion on the SDRAM bank handshake failed");
            $display("Checks failed");
            $fatal(1, "Stopping at the first failed assertion");
        end
    end

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic fill_tile_rom;
        logic [15:0] word;
        for (int w = 0; w < tile_words; w++) begin
            word = '0;
            repeat (16) begin
                lfsr_q = lfsr_step(lfsr_q);
                word   = {word[14:0], lfsr_q[0]};
            end
            tile_mem[w] = word;
        end
    endtask

    function automatic logic [15:0] bank_word(input logic [21:0] addr);
        logic [21:0] off;
        if (addr >= tile_base) begin
            off = addr - tile_base;
            return tile_mem[off[12:0]];
        end
        return 16'(addr - map_base + 22'd3);
    endfunction

    // The 16-clock tile budget leaves two spare cycles per fetch
    task automatic draw_delay(output int extra);
        extra = 0;
        if (bp_en && delay_credit > 0) begin
            lfsr_q = lfsr_step(lfsr_q);
            if (lfsr_q[0]) begin
                extra        = 1;
                delay_credit = delay_credit - 1;
            end
        end
    endtask

    // SDRAM bank model serving one read at a time
    always @(posedge clk) begin
        ba_ack <= 1'b0;
        ba_dok <= 1'b0;
        ba_rdy <= 1'b0;
        if (!arst_n) begin
            bank_st <= bank_idle;
        end else begin
            case (bank_st)
                bank_idle: begin
                    if (ba_rd) begin
                        rd_addr <= ba_addr;
                        // Each tile fetch opens with its map word
                        if (ba_addr < tile_base) begin
                            delay_credit = 2;
                        end
                        draw_delay(extra_cycles);
                        if (extra_cycles == 0) begin
                            ba_ack  <= 1'b1;
                            bank_st <= bank_data;
                        end else begin
                            wait_cnt <= extra_cycles;
                            bank_st  <= bank_ack;
                        end
                    end
                end
                bank_ack: begin
                    if (wait_cnt <= 1) begin
                        ba_ack  <= 1'b1;
                        bank_st <= bank_data;
                    end else begin
                        wait_cnt <= wait_cnt - 1;
                    end
                end
                bank_data: begin
                    draw_delay(extra_cycles);
                    if (extra_cycles == 0) begin
                        ba_dok    <= 1'b1;
                        ba_rdy    <= 1'b1;
                        data_read <= bank_word(rd_addr);
                        bank_st   <= bank_idle;
                    end else begin
                        wait_cnt <= extra_cycles;
                        bank_st  <= bank_dok;
                    end
                end
                bank_dok: begin
                    if (wait_cnt <= 1) begin
                        ba_dok    <= 1'b1;
                        ba_rdy    <= 1'b1;
                        data_read <= bank_word(rd_addr);
                        bank_st   <= bank_idle;
                    end else begin
                        wait_cnt <= wait_cnt - 1;
                    end
                end
                default: bank_st <= bank_idle;
            endcase
        end
    end

    // Outputs stay black whenever either blanking signal is active
    always @(negedge clk) begin
        if (arst_n && pxl_cen && !(LHBL_dly && LVBL_dly)) begin
            check_value("rgb in blanking", {red, green, blue}, 15'd0);
        end
    end

    task automatic wait_strobe;
        do @(negedge clk); while (!pxl_cen);
    endtask

    function automatic logic [3:0] expected_code(input int x, input int y);
        int          map_addr;
        logic [8:0]  code;
        int          row_addr;
        logic [31:0] row_bits;
        map_addr = (y / 8) * tile_cols + x / 8;
        code     = 9'(map_addr + 3);
        row_addr = code * 8 + y % 8;
        row_bits = {tile_mem[2 * row_addr], tile_mem[2 * row_addr + 1]};
        return row_bits[31 - 4 * (x % 8) -: 4];
    endfunction

    // Walks one frame from its first visible pixel to the vertical blank
    task automatic scan_frame(input int mode);
        int          x;
        int          y;
        logic [14:0] exp_rgb;
        wait_strobe();
        while (LVBL_dly) wait_strobe();
        while (!LVBL_dly) wait_strobe();
        x = 0;
        y = 0;
        while (LVBL_dly) begin
            if (LHBL_dly) begin
                if (mode == scan_image) begin
                    exp_rgb = pal_ref[expected_code(x, y)];
                end else begin
                    exp_rgb = pal_ref[0];
                end
                if (mode != scan_count) begin
                    check_value($sformatf("rgb(%0d,%0d)", x, y), {red, green, blue}, exp_rgb);
                end
                x++;
            end else if (x != 0) begin
                check_value("visible pixels per line", x, h_active);
                x = 0;
                y++;
            end
            wait_strobe();
        end
        check_value("visible lines per frame", y, v_active);
    endtask

    task automatic write_palette(input bit alt);
        logic [14:0] value;
        for (int k = 0; k < pal_entries; k++) begin
            value = alt ? 15'h7fff - 15'(k) * 15'h0421 : 15'(k) * 15'h0843;
            @(posedge clk);
            pal_we     <= 1'b1;
            pal_addr   <= 4'(k);
            pal_din    <= value;
            pal_ref[k] = value;
        end
        @(posedge clk);
        pal_we <= 1'b0;
    endtask

    function automatic logic sync_level(input bit vertical);
        return vertical ? VS : HS;
    endfunction

    task automatic check_sync_period(input bit vertical, input int expected);
        int t0;
        @(negedge clk);
        while (sync_level(vertical)) @(negedge clk);
        while (!sync_level(vertical)) @(negedge clk);
        t0 = cycle_cnt;
        while (sync_level(vertical)) @(negedge clk);
        while (!sync_level(vertical)) @(negedge clk);
        check_value(vertical ? "VS period" : "HS period", cycle_cnt - t0, expected);
    endtask

    task automatic raster_timing;
        logic prev;
        @(negedge clk);
        check_value("HS after reset", HS, 1'b0);
        check_value("VS after reset", VS, 1'b0);
        check_value("LHBL_dly after reset", LHBL_dly, 1'b0);
        check_value("LVBL_dly after reset", LVBL_dly, 1'b0);
        check_value("rgb after reset", {red, green, blue}, 15'd0);
        scan_frame(scan_count);
        prev = pxl_cen;
        repeat (8) begin
            @(negedge clk);
            check_value("pxl2_cen", pxl2_cen, 1'b1);
            check_value("pxl_cen", pxl_cen, !prev);
            prev = pxl_cen;
        end
        check_sync_period(1'b0, h_total * 2);
        check_sync_period(1'b1, frame_cycles);
    endtask

    task automatic frame_image;
        write_palette(1'b0);
        scan_frame(scan_image);
    endtask

    // Starts in the vertical blank left by the previous scan
    task automatic palette_update;
        write_palette(1'b1);
        scan_frame(scan_image);
    endtask

    task automatic layer_disable;
        @(posedge clk);
        char_en <= 1'b0;
        scan_frame(scan_flat);
        @(posedge clk);
        char_en <= 1'b1;
    endtask

    task automatic back_pressure;
        @(posedge clk);
        bp_en <= 1'b1;
        scan_frame(scan_image);
        @(posedge clk);
        bp_en <= 1'b0;
    endtask

    initial begin
        fill_tile_rom();
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        raster_timing();
        frame_image();
        palette_update();
        layer_disable();
        back_pressure();
        if (uut.u_arbiter.u_props.failed) begin
            $display("A bound assertion on the SDRAM bank handshake failed");
            $display("Checks failed");
            $fatal(1, "Run ended after a failed assertion");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* build.f */
logic/game_pkg.sv
logic/rom_slot_if.sv
logic/vid_timer.sv
logic/char_fetch.sv
logic/rom_arbiter.sv
logic/pal_lut.sv
logic/mini_game.sv
bench/mini_game_properties.sv
bench/mini_game_tb.sv

/* logic/char_fetch.sv */
`default_nettype none

module char_fetch (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                pxl_cen,
    input  logic [6:0]          hdump,
    input  logic [5:0]          vdump,
    input  logic                char_en,
    rom_slot_if.client          map_slot,
    rom_slot_if.client          tile_slot,
    output game_pkg::pxl_code_t pxl
);
    import game_pkg::*;

    typedef enum logic [1:0] {
        fetch_idle,
        fetch_map,
        fetch_tile
    } fetch_state_t;

    fetch_state_t state;
    logic [3:0]   next_col;
    logic [5:0]   next_line;
    logic [2:0]   line_lo;
    logic         tile_start;
    logic         fetch_go;
    logic         row_vld;
    tile_row_t    row_buf;
    tile_row_t    pix_sr;

    // Column one tile ahead; the last slot of a line targets column 0 of the next
    always_comb begin
        next_col  = hdump[6:3] + 4'd1;
        next_line = vdump;
        if (next_col == h_tiles) begin
            next_col  = '0;
            next_line = (vdump == v_total - 1) ? '0 : vdump + 6'd1;
        end
    end

    assign tile_start = pxl_cen && hdump[2:0] == 3'd0;
    assign fetch_go   = tile_start && next_col < tile_cols && next_line[5:3] < tile_rows;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state         <= fetch_idle;
            map_slot.cs   <= 1'b0;
            tile_slot.cs  <= 1'b0;
            row_vld       <= 1'b0;
        end else begin
            // The shifter consumes the buffered row at every boundary
            if (tile_start) begin
                row_vld <= 1'b0;
            end
            case (state)
                fetch_idle: begin
                    if (fetch_go) begin
                        map_slot.cs <= 1'b1;
                        state       <= fetch_map;
                    end
                end
                fetch_map: begin
                    if (map_slot.ok) begin
                        map_slot.cs  <= 1'b0;
                        tile_slot.cs <= 1'b1;
                        state        <= fetch_tile;
                    end
                end
                fetch_tile: begin
                    if (tile_slot.ok) begin
                        tile_slot.cs <= 1'b0;
                        row_vld      <= 1'b1;
                        state        <= fetch_idle;
                    end
                end
                default: state <= fetch_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == fetch_idle && fetch_go) begin
            map_slot.addr <= map_aw'(next_line[5:3] * tile_cols + next_col);
            line_lo       <= next_line[2:0];
        end
        // Tile code times 8 plus the line inside the tile
        if (state == fetch_map && map_slot.ok) begin
            tile_slot.addr <= tile_aw'({map_slot.data[8:0], line_lo});
        end
        if (state == fetch_tile && tile_slot.ok) begin
            row_buf <= tile_slot.data;
        end
    end

    // A late fetch shows as a blank tile rather than a stall
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            if (hdump[2:0] == 3'd0) begin
                pix_sr <= row_vld ? row_buf : '0;
            end else begin
                pix_sr <= {pix_sr[27:0], 4'd0};
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pxl <= '0;
        end else if (pxl_cen) begin
            pxl <= char_en ? pix_sr[31:28] : '0;
        end
    end

endmodule

`default_nettype wire

/* logic/game_pkg.sv */
`default_nettype none

package game_pkg;

    // Raster geometry kept small for short simulations
    localparam int h_total      = 96;
    localparam int h_active     = 64;
    localparam int h_sync_start = 72;
    localparam int h_sync_len   = 8;
    localparam int v_total      = 40;
    localparam int v_active     = 32;
    localparam int v_sync_start = 34;
    localparam int v_sync_len   = 2;

    // Tile slots per line including blanking
    localparam int h_tiles = h_total / 8;

    // Shifter load and output register followed by the palette register
    localparam int fetch_delay = 2;
    localparam int pixel_delay = fetch_delay + 1;

    localparam int tile_cols   = 8;
    localparam int tile_rows   = 4;
    localparam int map_aw      = 5;
    localparam int tile_aw     = 12;
    localparam int pal_entries = 16;

    // Word addresses of the two ROM regions in the SDRAM bank
    localparam logic [21:0] map_base  = 22'h00_0000;
    localparam logic [21:0] tile_base = 22'h01_0000;

    typedef logic [15:0] map_word_t;
    // Eight 4-bit pixels with the leftmost in the top nibble
    typedef logic [31:0] tile_row_t;
    typedef logic [3:0]  pxl_code_t;

    typedef struct packed {
        logic [4:0] red;
        logic [4:0] green;
        logic [4:0] blue;
    } rgb_t;

endpackage

`default_nettype wire

/* logic/mini_game.sv */
`default_nettype none

module mini_game (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        char_en,
    input  logic        pal_we,
    input  logic [3:0]  pal_addr,
    input  logic [14:0] pal_din,
    input  logic        ba_ack,
    input  logic        ba_dok,
    input  logic        ba_rdy,
    input  logic [15:0] data_read,
    output logic        pxl2_cen,
    output logic        pxl_cen,
    output logic [4:0]  red,
    output logic [4:0]  green,
    output logic [4:0]  blue,
    output logic        HS,
    output logic        VS,
    output logic        LHBL_dly,
    output logic        LVBL_dly,
    output logic        ba_rd,
    output logic [21:0] ba_addr
);
    import game_pkg::*;

    logic [6:0] hdump;
    logic [5:0] vdump;
    logic       LHBL;
    logic       LVBL;
    pxl_code_t  pxl;

    rom_slot_if #(.data_t(map_word_t), .aw(map_aw))  map_slot ();
    rom_slot_if #(.data_t(tile_row_t), .aw(tile_aw)) tile_slot ();

    vid_timer u_timer (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .pxl2_cen ( pxl2_cen ),
        .pxl_cen  ( pxl_cen  ),
        .hdump    ( hdump    ),
        .vdump    ( vdump    ),
        .HS       ( HS       ),
        .VS       ( VS       ),
        .LHBL     ( LHBL     ),
        .LVBL     ( LVBL     ),
        .LHBL_dly ( LHBL_dly ),
        .LVBL_dly ( LVBL_dly )
    );

    char_fetch u_char (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .pxl_cen   ( pxl_cen   ),
        .hdump     ( hdump     ),
        .vdump     ( vdump     ),
        .char_en   ( char_en   ),
        .map_slot  ( map_slot  ),
        .tile_slot ( tile_slot ),
        .pxl       ( pxl       )
    );

    // Single SDRAM bank shared by the map and tile clients
    rom_arbiter u_arbiter (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .ba_ack    ( ba_ack    ),
        .ba_dok    ( ba_dok    ),
        .ba_rdy    ( ba_rdy    ),
        .data_read ( data_read ),
        .map_slot  ( map_slot  ),
        .tile_slot ( tile_slot ),
        .ba_rd     ( ba_rd     ),
        .ba_addr   ( ba_addr   )
    );

    pal_lut u_pal (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .pxl_cen  ( pxl_cen  ),
        .pxl      ( pxl      ),
        .LHBL     ( LHBL     ),
        .LVBL     ( LVBL     ),
        .pal_we   ( pal_we   ),
        .pal_addr ( pal_addr ),
        .pal_din  ( pal_din  ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     )
    );

endmodule

`default_nettype wire

/* logic/pal_lut.sv */
`default_nettype none

module pal_lut (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                pxl_cen,
    input  game_pkg::pxl_code_t pxl,
    input  logic                LHBL,
    input  logic                LVBL,
    input  logic                pal_we,
    input  logic [3:0]          pal_addr,
    input  logic [14:0]         pal_din,
    output logic [4:0]          red,
    output logic [4:0]          green,
    output logic [4:0]          blue
);
    import game_pkg::*;

    rgb_t                   pal_mem [pal_entries];
    rgb_t                   rgb_q;
    logic [fetch_delay-1:0] hb_sr;
    logic [fetch_delay-1:0] vb_sr;

    // Entry packs red, green and blue from the top bit down
    always_ff @(posedge clk) begin
        if (pal_we) begin
            pal_mem[pal_addr] <= rgb_t'(pal_din);
        end
    end

    // Blanking delayed to match the code arriving from the fetcher
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hb_sr <= '0;
            vb_sr <= '0;
            rgb_q <= '0;
        end else if (pxl_cen) begin
            hb_sr <= {hb_sr[fetch_delay-2:0], LHBL};
            vb_sr <= {vb_sr[fetch_delay-2:0], LVBL};
            rgb_q <= (hb_sr[fetch_delay-1] && vb_sr[fetch_delay-1]) ? pal_mem[pxl] : '0;
        end
    end

    assign red   = rgb_q.red;
    assign green = rgb_q.green;
    assign blue  = rgb_q.blue;

endmodule

`default_nettype wire

/* logic/rom_arbiter.sv */
`default_nettype none

module rom_arbiter (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        ba_ack,
    input  logic        ba_dok,
    input  logic        ba_rdy,
    input  logic [15:0] data_read,
    rom_slot_if.server  map_slot,
    rom_slot_if.server  tile_slot,
    output logic        ba_rd,
    output logic [21:0] ba_addr
);
    import game_pkg::*;

    typedef enum logic [1:0] {
        arb_idle,
        arb_req,
        arb_wait,
        arb_second
    } arb_state_t;

    arb_state_t  state;
    logic        sel_tile;
    logic        grant_map;
    logic        grant_tile;
    logic        second_done;
    logic [15:0] tile_hi;

    // A slot whose ok is out this cycle still shows cs, so it is skipped
    assign grant_map  = state == arb_idle && map_slot.cs && !map_slot.ok;
    assign grant_tile = state == arb_idle && !grant_map && tile_slot.cs && !tile_slot.ok;

    // Burst end marks the odd word of a tile row
    assign second_done = state == arb_second && !ba_rd && ba_dok && ba_rdy;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= arb_idle;
            ba_rd        <= 1'b0;
            sel_tile     <= 1'b0;
            map_slot.ok  <= 1'b0;
            tile_slot.ok <= 1'b0;
        end else begin
            map_slot.ok  <= 1'b0;
            tile_slot.ok <= 1'b0;
            case (state)
                arb_idle: begin
                    if (grant_map || grant_tile) begin
                        ba_rd    <= 1'b1;
                        sel_tile <= grant_tile;
                        state    <= arb_req;
                    end
                end
                arb_req: begin
                    if (ba_ack) begin
                        ba_rd <= 1'b0;
                        state <= arb_wait;
                    end
                end
                arb_wait: begin
                    if (ba_dok) begin
                        if (sel_tile) begin
                            ba_rd <= 1'b1;
                            state <= arb_second;
                        end else begin
                            map_slot.ok <= 1'b1;
                            state       <= arb_idle;
                        end
                    end
                end
                arb_second: begin
                    if (ba_rd && ba_ack) begin
                        ba_rd <= 1'b0;
                    end
                    if (second_done) begin
                        tile_slot.ok <= 1'b1;
                        state        <= arb_idle;
                    end
                end
                default: state <= arb_idle;
            endcase
        end
    end

    // Tile rows sit at even word 2n and odd word 2n+1
    always_ff @(posedge clk) begin
        if (grant_map) begin
            ba_addr <= map_base + 22'(map_slot.addr);
        end
        if (grant_tile) begin
            ba_addr <= tile_base + 22'({tile_slot.addr, 1'b0});
        end
        if (state == arb_wait && ba_dok) begin
            if (sel_tile) begin
                tile_hi <= data_read;
                ba_addr <= ba_addr + 22'd1;
            end else begin
                map_slot.data <= data_read;
            end
        end
        if (second_done) begin
            tile_slot.data <= {tile_hi, data_read};
        end
    end

endmodule

`default_nettype wire

/* logic/rom_slot_if.sv */
`default_nettype none

// One ROM client port holding cs and addr until the ok pulse
interface rom_slot_if #(
    parameter type data_t = logic [15:0],
    parameter int  aw     = 8
);
    logic          cs;
    logic [aw-1:0] addr;
    data_t         data;
    logic          ok;

    modport client (
        output cs,
        output addr,
        input  data,
        input  ok
    );

    modport server (
        input  cs,
        input  addr,
        output data,
        output ok
    );
endinterface

`default_nettype wire

/* logic/vid_timer.sv */
`default_nettype none

module vid_timer (
    input  logic       clk,
    input  logic       arst_n,
    output logic       pxl2_cen,
    output logic       pxl_cen,
    output logic [6:0] hdump,
    output logic [5:0] vdump,
    output logic       HS,
    output logic       VS,
    output logic       LHBL,
    output logic       LVBL,
    output logic       LHBL_dly,
    output logic       LVBL_dly
);
    import game_pkg::*;

    logic [pixel_delay-1:0] lhbl_sr;
    logic [pixel_delay-1:0] lvbl_sr;

    // Full rate enable and half rate pixel strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            pxl2_cen <= 1'b1;
            pxl_cen  <= ~pxl_cen;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hdump <= '0;
            vdump <= '0;
        end else if (pxl_cen) begin
            if (hdump == h_total - 1) begin
                hdump <= '0;
                vdump <= (vdump == v_total - 1) ? '0 : vdump + 6'd1;
            end else begin
                hdump <= hdump + 7'd1;
            end
        end
    end

    assign HS   = hdump >= h_sync_start && hdump < h_sync_start + h_sync_len;
    assign VS   = vdump >= v_sync_start && vdump < v_sync_start + v_sync_len;
    assign LHBL = hdump < h_active;
    assign LVBL = vdump < v_active;

    // Blanking aligned with the colour output of the pixel pipeline
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lhbl_sr <= '0;
            lvbl_sr <= '0;
        end else if (pxl_cen) begin
            lhbl_sr <= {lhbl_sr[pixel_delay-2:0], LHBL};
            lvbl_sr <= {lvbl_sr[pixel_delay-2:0], LVBL};
        end
    end

    assign LHBL_dly = lhbl_sr[pixel_delay-1];
    assign LVBL_dly = lvbl_sr[pixel_delay-1];

endmodule

`default_nettype wire
